//--- hdl/fetch_pkg.sv
package fetch_pkg;

	// address map
	localparam logic [31:0] reset_pc = 32'h3000_0000; // boot address.
	localparam logic [31:0] cache_base = 32'ha000_0000; // first cacheable byte.
	localparam logic [31:0] cache_limit = 32'ha200_0000; // first byte past the region.

	// cache geometry
	localparam int unsigned line_words = 4; // words per line.
	localparam int unsigned index_bits = 4; // sixteen lines.
	localparam int unsigned offset_bits = 4; // byte offset within a line.
	localparam int unsigned word_bits = offset_bits - 2; // word select within a line.
	localparam int unsigned tag_bits = 32 - index_bits - offset_bits;
	localparam int unsigned line_count = 2 ** index_bits;
	localparam logic [3:0] burst_len = 4'(line_words - 1); // arlen of a line fill.

	// AXI4 encodings
	localparam logic [1:0] burst_fixed = 2'b00; // single beats.
	localparam logic [1:0] burst_incr = 2'b01; // line fills.
	localparam logic [1:0] resp_okay = 2'b00;

	typedef enum logic [2:0] {
		idle, // fetch start, pc is settled.
		lookup, // cache answers the lookup.
		bus_req, // ar_valid up, waiting for ar_ready.
		bus_wait, // single uncached beat.
		fill, // line burst, one cache write per beat.
		deliver // output register toward decode.
	} fetch_state_e;

	typedef struct packed {
		logic [31:0] addr;
		logic [3:0] len;
		logic [1:0] burst;
	} axi_ar_t;

	typedef struct packed {
		logic [31:0] data;
		logic [1:0] resp;
		logic last;
	} axi_r_t;

	typedef struct packed {
		logic [31:0] addr;
		logic fill; // write one word instead of a lookup.
		logic [31:0] fill_data;
		logic fill_last; // last word, line becomes valid.
	} icache_req_t;

	typedef struct packed {
		logic hit;
		logic [31:0] data;
	} icache_rsp_t;

	typedef struct packed {
		logic [31:0] pc;
		logic [31:0] inst;
		logic bus_error; // some beat of this fetch came back non-OKAY.
	} fetch_out_t;

endpackage

//--- hdl/fetch_icache.sv
module fetch_icache (
	input  logic clock,
	input  logic rst_n,
	input  logic cache_req_valid,
	input  fetch_pkg::icache_req_t cache_req,
	output fetch_pkg::icache_rsp_t cache_rsp
);

	// request address split into tag, line index and word.
	logic [fetch_pkg::tag_bits-1:0] req_tag;
	logic [fetch_pkg::index_bits-1:0] req_index;
	logic [fetch_pkg::word_bits-1:0] req_word;

	// storage arrays.
	logic [fetch_pkg::tag_bits-1:0] tag_mem [fetch_pkg::line_count];
	logic [31:0] data_mem [fetch_pkg::line_count][fetch_pkg::line_words];
	logic [fetch_pkg::line_count-1:0] valid_q;

	// registered lookup.
	logic lookup_q;
	logic [fetch_pkg::tag_bits-1:0] tag_q;
	logic [fetch_pkg::index_bits-1:0] index_q;
	logic [fetch_pkg::word_bits-1:0] word_q;
	logic line_hit;

	assign req_tag = cache_req.addr[31 -: fetch_pkg::tag_bits];
	assign req_index = cache_req.addr[fetch_pkg::offset_bits +: fetch_pkg::index_bits];
	assign req_word = cache_req.addr[2 +: fetch_pkg::word_bits];

	// valid bits and the registered lookup flag.
	always_ff @(posedge clock) begin
		if (!rst_n) begin
			valid_q <= '0;
			lookup_q <= 1'b0;
		end else begin
			lookup_q <= cache_req_valid && !cache_req.fill; // answer due next cycle.
			if (cache_req_valid && cache_req.fill) begin
				// every fill word clears the line's valid bit.
				// only a clean last word sets it again.
				valid_q[req_index] <= cache_req.fill_last;
			end
		end
	end

	// line fill, one word per request.
	always_ff @(posedge clock) begin
		if (cache_req_valid && cache_req.fill) begin
			data_mem[req_index][req_word] <= cache_req.fill_data;
			tag_mem[req_index] <= req_tag; // same tag on every beat.
		end
	end

	// lookup address, compared one cycle later.
	always_ff @(posedge clock) begin
		if (cache_req_valid && !cache_req.fill) begin
			tag_q <= req_tag;
			index_q <= req_index;
			word_q <= req_word;
		end
	end

	assign line_hit = valid_q[index_q] && (tag_mem[index_q] == tag_q);

	always_comb begin
		cache_rsp.hit = lookup_q && line_hit; // only meaningful after a lookup.
		cache_rsp.data = data_mem[index_q][word_q];
	end

endmodule

//--- hdl/fetch_unit.sv
module fetch_unit (
	input  logic clock,
	input  logic rst_n,

	// AXI4 read channels.
	output logic ar_valid,
	input  logic ar_ready,
	output fetch_pkg::axi_ar_t ar,
	input  logic r_valid,
	output logic r_ready,
	input  fetch_pkg::axi_r_t r,

	// instruction cache.
	output logic cache_req_valid,
	output fetch_pkg::icache_req_t cache_req,
	input  fetch_pkg::icache_rsp_t cache_rsp,

	// back end redirect.
	input  logic redirect_valid,
	input  logic [31:0] redirect_pc,

	// decode.
	output logic out_valid,
	input  logic out_ready,
	output fetch_pkg::fetch_out_t out
);

	fetch_pkg::fetch_state_e state;
	logic [31:0] pc;
	logic pending; // a redirect hit a running bus transaction.
	logic [fetch_pkg::word_bits-1:0] beat_cnt; // word offset of the next fill beat.
	logic err_acc; // error seen on an earlier beat of this burst.

	logic cacheable;
	logic ar_fire;
	logic r_fire;
	logic beat_err;
	logic discard;
	logic [fetch_pkg::word_bits-1:0] pc_word;

	assign cacheable = (pc >= fetch_pkg::cache_base) && (pc < fetch_pkg::cache_limit);
	assign pc_word = pc[2 +: fetch_pkg::word_bits];
	assign ar_fire = ar_valid && ar_ready;
	assign r_ready = (state == fetch_pkg::bus_wait) || (state == fetch_pkg::fill);
	assign r_fire = r_valid && r_ready;
	assign beat_err = r.resp != fetch_pkg::resp_okay;
	assign discard = pending || redirect_valid; // data of the old path is dropped.

	// lookup in idle, fill writes as the beats arrive.
	always_comb begin
		cache_req_valid = 1'b0;
		cache_req.addr = pc;
		cache_req.fill = 1'b0;
		cache_req.fill_data = r.data;
		cache_req.fill_last = 1'b0;
		if (state == fetch_pkg::idle && cacheable) begin
			cache_req_valid = 1'b1;
		end else if (state == fetch_pkg::fill && r_fire) begin
			cache_req_valid = 1'b1;
			cache_req.fill = 1'b1;
			cache_req.addr = {ar.addr[31:fetch_pkg::offset_bits], beat_cnt, 2'b00};
			cache_req.fill_last = r.last && !beat_err && !err_acc; // no allocation on error.
		end
	end

	always_ff @(posedge clock) begin
		if (!rst_n) begin
			state <= fetch_pkg::idle;
			pc <= fetch_pkg::reset_pc;
			pending <= 1'b0;
			ar_valid <= 1'b0;
			out_valid <= 1'b0;
			beat_cnt <= '0;
			err_acc <= 1'b0;
		end else begin
			case (state)
				fetch_pkg::idle: begin
					if (redirect_valid) begin
						pc <= redirect_pc; // restart from the new target.
					end else if (cacheable) begin
						state <= fetch_pkg::lookup;
					end else begin
						ar_valid <= 1'b1;
						state <= fetch_pkg::bus_req;
					end
				end
				fetch_pkg::lookup: begin
					if (redirect_valid) begin
						pc <= redirect_pc;
						state <= fetch_pkg::idle;
					end else if (cache_rsp.hit) begin
						state <= fetch_pkg::deliver;
					end else begin
						ar_valid <= 1'b1; // miss, fetch the whole line.
						state <= fetch_pkg::bus_req;
					end
				end
				fetch_pkg::bus_req: begin
					// ar_valid stays up until the handshake, redirect or not.
					if (redirect_valid) begin
						pc <= redirect_pc;
						pending <= 1'b1;
					end
					if (ar_fire) begin
						ar_valid <= 1'b0;
						beat_cnt <= '0;
						err_acc <= 1'b0;
						if (ar.burst == fetch_pkg::burst_incr) begin
							state <= fetch_pkg::fill;
						end else begin
							state <= fetch_pkg::bus_wait;
						end
					end
				end
				fetch_pkg::bus_wait: begin
					if (redirect_valid) begin
						pc <= redirect_pc;
					end
					if (r_fire) begin
						pending <= 1'b0;
						state <= discard ? fetch_pkg::idle : fetch_pkg::deliver;
					end else if (redirect_valid) begin
						pending <= 1'b1;
					end
				end
				fetch_pkg::fill: begin
					if (redirect_valid) begin
						pc <= redirect_pc;
					end
					if (r_fire) begin
						beat_cnt <= beat_cnt + 1'b1;
						err_acc <= err_acc || beat_err;
					end
					if (r_fire && r.last) begin
						pending <= 1'b0; // line is complete, even on a dropped path.
						state <= discard ? fetch_pkg::idle : fetch_pkg::deliver;
					end else if (redirect_valid) begin
						pending <= 1'b1;
					end
				end
				fetch_pkg::deliver: begin
					if (redirect_valid) begin
						pc <= redirect_pc; // throw the held instruction away.
						out_valid <= 1'b0;
						state <= fetch_pkg::idle;
					end else if (!out_valid) begin
						out_valid <= 1'b1;
					end else if (out_ready) begin
						out_valid <= 1'b0;
						pc <= pc + 32'd4;
						state <= fetch_pkg::idle;
					end
				end
				default: state <= fetch_pkg::idle;
			endcase
		end
	end

	// request payload and the instruction register.
	always_ff @(posedge clock) begin
		case (state)
			fetch_pkg::idle: begin
				ar.addr <= pc;
				ar.len <= 4'd0;
				ar.burst <= fetch_pkg::burst_fixed;
			end
			fetch_pkg::lookup: begin
				if (cache_rsp.hit) begin
					out.inst <= cache_rsp.data;
					out.bus_error <= 1'b0;
				end else begin
					ar.addr <= {pc[31:fetch_pkg::offset_bits], {fetch_pkg::offset_bits{1'b0}}};
					ar.len <= fetch_pkg::burst_len;
					ar.burst <= fetch_pkg::burst_incr;
				end
			end
			fetch_pkg::bus_wait: begin
				if (r_fire) begin
					out.inst <= r.data;
					out.bus_error <= beat_err;
				end
			end
			fetch_pkg::fill: begin
				if (r_fire && beat_cnt == pc_word) begin
					out.inst <= r.data; // the word the pc asked for.
				end
				if (r_fire && r.last) begin
					out.bus_error <= err_acc || beat_err;
				end
			end
			fetch_pkg::deliver: begin
				if (!out_valid) begin
					out.pc <= pc;
				end
			end
			default: ;
		endcase
	end

endmodule

//--- hdl/fetch_top.sv
module fetch_top (
	input  logic clock,
	input  logic rst_n,

	// AXI4 read port toward memory.
	output logic ar_valid,
	input  logic ar_ready,
	output fetch_pkg::axi_ar_t ar,
	input  logic r_valid,
	output logic r_ready,
	input  fetch_pkg::axi_r_t r,

	// redirect from the back end.
	input  logic redirect_valid,
	input  logic [31:0] redirect_pc,

	// instruction stream toward decode.
	output logic out_valid,
	input  logic out_ready,
	output fetch_pkg::fetch_out_t out
);

	logic cache_req_valid;
	fetch_pkg::icache_req_t cache_req;
	fetch_pkg::icache_rsp_t cache_rsp;

	fetch_unit u_fetch_unit (
		.clock(clock),
		.rst_n(rst_n),
		.ar_valid(ar_valid),
		.ar_ready(ar_ready),
		.ar(ar),
		.r_valid(r_valid),
		.r_ready(r_ready),
		.r(r),
		.cache_req_valid(cache_req_valid),
		.cache_req(cache_req),
		.cache_rsp(cache_rsp),
		.redirect_valid(redirect_valid),
		.redirect_pc(redirect_pc),
		.out_valid(out_valid),
		.out_ready(out_ready),
		.out(out)
	);

	fetch_icache u_icache (
		.clock(clock),
		.rst_n(rst_n),
		.cache_req_valid(cache_req_valid),
		.cache_req(cache_req),
		.cache_rsp(cache_rsp)
	);

endmodule

//--- bench/fetch_mem_model.sv
module fetch_mem_model #(
	parameter logic [31:0] err_base = 32'h0, // reads in [err_base, err_limit) answer SLVERR.
	parameter logic [31:0] err_limit = 32'h0,
	parameter int seed_init = 1
) (
	input  logic clock,
	input  logic rst_n,
	input  logic ar_valid,
	output logic ar_ready,
	input  fetch_pkg::axi_ar_t ar,
	output logic r_valid,
	input  logic r_ready,
	output fetch_pkg::axi_r_t r
);

	integer seed;
	logic busy; // burst accepted, beats still to send.
	logic beat_taken; // r handshake on the last rising edge.
	logic incr;
	logic [31:0] beat_addr;
	int beats_left;
	int ar_delay;
	int r_delay;

	function int pick_delay();
		return {$random(seed)} % 4; // zero to three idle cycles.
	endfunction

	// handshakes are taken on the rising edge.
	initial begin
		seed = seed_init;
		busy = 1'b0;
		beat_taken = 1'b0;
		forever begin
			@(posedge clock);
			if (!rst_n) begin
				busy = 1'b0;
				beat_taken = 1'b0;
				ar_delay = 0;
				r_delay = 0;
			end else if (ar_valid && ar_ready) begin
				busy = 1'b1;
				beat_addr = ar.addr;
				beats_left = ar.len + 1;
				incr = ar.burst == fetch_pkg::burst_incr;
				ar_delay = pick_delay();
				r_delay = pick_delay();
			end else if (r_valid && r_ready) begin
				beat_taken = 1'b1;
				beats_left = beats_left - 1;
				busy = beats_left != 0;
				if (incr) begin
					beat_addr = beat_addr + 32'd4; // INCR walks the line in order.
				end
			end
		end
	end

	// outputs change on the falling edge only.
	initial begin
		ar_ready = 1'b0;
		r_valid = 1'b0;
		r = '0;
		forever begin
			@(negedge clock);
			if (!rst_n) begin
				ar_ready = 1'b0;
				r_valid = 1'b0;
			end else begin
				if (beat_taken) begin
					r_valid = 1'b0;
					beat_taken = 1'b0;
					r_delay = pick_delay();
				end
				ar_ready = 1'b0;
				if (!busy && ar_valid) begin
					if (ar_delay == 0) begin
						ar_ready = 1'b1;
					end else begin
						ar_delay = ar_delay - 1;
					end
				end
				if (busy && !r_valid) begin
					if (r_delay == 0) begin
						r_valid = 1'b1;
						r.data = beat_addr ^ 32'h5a5a_0013; // scrambled address as data.
						r.resp = (beat_addr >= err_base && beat_addr < err_limit) ?
							2'b10 : fetch_pkg::resp_okay; // SLVERR inside the window.
						r.last = beats_left == 1;
					end else begin
						r_delay = r_delay - 1;
					end
				end
			end
		end
	end

endmodule

//--- bench/fetch_tb.sv
module fetch_tb;

	localparam logic [31:0] err_base = 32'ha000_0440; // one line that answers SLVERR.
	localparam logic [31:0] err_limit = 32'ha000_0450;
	localparam logic [31:0] line_pc = 32'ha000_0100; // two cacheable lines from here.
	localparam logic [31:0] bp_pc = 32'h3000_1000;
	localparam logic [31:0] miss_pc = 32'ha000_0320;
	localparam logic [31:0] jump_pc = 32'h3000_2040;
	localparam logic [31:0] err_pc = 32'ha000_0444;
	localparam int rand_seed = 32'h19a0;
	localparam int fetch_total = 40; // 36 fetches over all tests plus margin.
	localparam int cycle_limit = fetch_total * 100; // generous bound per fetch.

	logic clock = 1'b0;
	logic rst_n;
	logic ar_valid;
	logic ar_ready;
	fetch_pkg::axi_ar_t ar;
	logic r_valid;
	logic r_ready;
	fetch_pkg::axi_r_t r;
	logic redirect_valid;
	logic [31:0] redirect_pc;
	logic out_valid;
	logic out_ready;
	fetch_pkg::fetch_out_t out;

	integer seed;
	int cycle_count = 0;
	int errors = 0;
	int tests_run = 0;
	int tests_failed = 0;
	fetch_pkg::axi_ar_t ar_log[$]; // every AR handshake in order.
	fetch_pkg::fetch_out_t accepted[$]; // every instruction taken by decode.

	always #5 clock = ~clock;

	fetch_top i_dut (.*);

	fetch_mem_model #(
		.err_base(err_base),
		.err_limit(err_limit),
		.seed_init(rand_seed)
	) u_mem (.*);

	always @(posedge clock) begin
		cycle_count = cycle_count + 1;
		if (rst_n && ar_valid && ar_ready) ar_log.push_back(ar);
		if (rst_n && out_valid && out_ready) accepted.push_back(out);
		if (cycle_count >= cycle_limit) begin
			$display("ERROR: run stopped after %0d cycles without finishing", cycle_limit);
			$display("Simulation failed");
			$finish;
		end
	end

	function automatic logic [31:0] mem_word(input logic [31:0] addr);
		return addr ^ 32'h5a5a_0013;
	endfunction

	task automatic report_mismatch(input string name, input logic [31:0] expected,
			input logic [31:0] actual);
		errors = errors + 1;
		$display("MISMATCH at %0t: %s expected %h got %h", $time, name, expected, actual);
	endtask

	task automatic report_failure(input string what);
		errors = errors + 1;
		$display("ERROR at %0t: %s", $time, what);
	endtask

	task automatic check_instruction(input fetch_pkg::fetch_out_t item, input logic [31:0] pc,
			input logic bus_error);
		if (item.pc !== pc) report_mismatch("out.pc", pc, item.pc);
		if (!bus_error && item.inst !== mem_word(pc)) begin
			report_mismatch("out.inst", mem_word(pc), item.inst); // error beats carry no data.
		end
		if (item.bus_error !== bus_error) begin
			report_mismatch("out.bus_error", bus_error, item.bus_error);
		end
	endtask

	task automatic check_ar(input int index, input logic [31:0] addr, input logic [3:0] len,
			input logic [1:0] burst);
		if (ar_log[index].addr !== addr) report_mismatch("ar.addr", addr, ar_log[index].addr);
		if (ar_log[index].len !== len) report_mismatch("ar.len", len, ar_log[index].len);
		if (ar_log[index].burst !== burst) report_mismatch("ar.burst", burst, ar_log[index].burst);
	endtask

	task automatic redirect_to(input logic [31:0] target);
		redirect_valid = 1'b1;
		redirect_pc = target;
		@(negedge clock);
		redirect_valid = 1'b0;
	endtask

	task automatic wait_out_valid(output int waited);
		waited = 0;
		while (!out_valid) begin
			@(negedge clock);
			waited = waited + 1;
		end
	endtask

	task automatic take_instruction(output fetch_pkg::fetch_out_t item, output int waited);
		wait_out_valid(waited);
		item = out;
		out_ready = 1'b1; // accepted on the next rising edge.
		@(negedge clock);
		out_ready = 1'b0;
	endtask

	// takes count instructions from start_pc on.
	// a hit_delay of zero skips the timing check.
	task automatic fetch_sequence(input logic [31:0] start_pc, input int count,
			input int hit_delay);
		fetch_pkg::fetch_out_t item;
		int waited;
		int i;
		for (i = 0; i < count; i++) begin
			take_instruction(item, waited);
			check_instruction(item, start_pc + 32'(4 * i), 1'b0);
			if (hit_delay > 0 && i > 0 && waited != hit_delay) begin
				report_mismatch("out_valid delay", hit_delay, waited);
			end
		end
	endtask

	task automatic close_test(input string name, input int start_errors);
		tests_run = tests_run + 1;
		if (errors == start_errors) begin
			$display("test %s: ok", name);
		end else begin
			tests_failed = tests_failed + 1;
			$display("test %s: %0d errors", name, errors - start_errors);
		end
	endtask

	task automatic uncached_sequence();
		int start_errors;
		int i;
		start_errors = errors;
		if ({out_valid, ar_valid, r_ready} !== 3'b000) begin
			report_failure("outputs active right after reset");
		end
		fetch_sequence(fetch_pkg::reset_pc, 8, 0);
		if (ar_log.size() != 8) begin
			report_failure($sformatf("expected 8 single reads, saw %0d", ar_log.size()));
		end else begin
			for (i = 0; i < 8; i++) begin
				check_ar(i, fetch_pkg::reset_pc + 32'(4 * i), 4'd0, fetch_pkg::burst_fixed);
			end
		end
		close_test("uncached sequence", start_errors);
	endtask

	task automatic line_fill();
		int start_errors;
		int start_ar;
		start_errors = errors;
		start_ar = ar_log.size();
		redirect_to(line_pc);
		fetch_sequence(line_pc, 8, 0);
		if (ar_log.size() - start_ar != 2) begin
			report_failure($sformatf("expected 2 line fills, saw %0d reads",
				ar_log.size() - start_ar));
		end else begin
			check_ar(start_ar, line_pc, 4'd3, fetch_pkg::burst_incr);
			check_ar(start_ar + 1, line_pc + 32'h10, 4'd3, fetch_pkg::burst_incr);
		end
		close_test("line fill", start_errors);
	endtask

	task automatic cache_reuse();
		int start_errors;
		int start_ar;
		start_errors = errors;
		start_ar = ar_log.size();
		redirect_to(line_pc);
		fetch_sequence(line_pc, 8, 3); // lookup, response, output register.
		if (ar_log.size() != start_ar) report_failure("fetch of cached lines went to the bus");
		close_test("cache reuse", start_errors);
	endtask

	task automatic decode_backpressure();
		fetch_pkg::fetch_out_t held;
		int start_errors;
		int waited;
		int stall;
		int i;
		int k;
		start_errors = errors;
		accepted.delete();
		redirect_to(bp_pc);
		for (i = 0; i < 8; i++) begin
			wait_out_valid(waited);
			held = out;
			stall = {$random(seed)} % 6;
			for (k = 0; k < stall; k++) begin
				@(negedge clock);
				if (!out_valid) report_failure("out_valid dropped while decode stalled");
				if (out.pc !== held.pc) report_mismatch("out.pc", held.pc, out.pc);
				if (out.inst !== held.inst) report_mismatch("out.inst", held.inst, out.inst);
				if (out.bus_error !== held.bus_error) begin
					report_mismatch("out.bus_error", held.bus_error, out.bus_error);
				end
			end
			out_ready = 1'b1;
			@(negedge clock);
			out_ready = 1'b0;
		end
		if (accepted.size() != 8) begin
			report_failure($sformatf("decode took %0d instructions, not 8", accepted.size()));
		end else begin
			for (i = 0; i < 8; i++) check_instruction(accepted[i], bp_pc + 32'(4 * i), 1'b0);
		end
		close_test("back-pressure", start_errors);
	endtask

	task automatic redirect_during_fill();
		fetch_pkg::fetch_out_t item;
		int start_errors;
		int start_ar;
		int waited;
		start_errors = errors;
		start_ar = ar_log.size();
		accepted.delete();
		redirect_to(miss_pc);
		while (ar_log.size() == start_ar) begin
			@(negedge clock);
		end
		if (!r_ready) report_failure("line burst not running when the redirect came");
		redirect_to(jump_pc);
		take_instruction(item, waited);
		check_instruction(item, jump_pc, 1'b0);
		if (accepted.size() != 1) report_failure("instruction of the dropped path delivered");
		if (ar_log.size() - start_ar != 2) begin
			report_failure($sformatf("expected 2 reads, saw %0d", ar_log.size() - start_ar));
		end else begin
			check_ar(start_ar, miss_pc & ~32'hf, 4'd3, fetch_pkg::burst_incr);
			check_ar(start_ar + 1, jump_pc, 4'd0, fetch_pkg::burst_fixed);
		end
		close_test("redirect during fill", start_errors);
	endtask

	task automatic error_refetch();
		fetch_pkg::fetch_out_t item;
		int start_errors;
		int start_ar;
		int waited;
		start_errors = errors;
		start_ar = ar_log.size();
		redirect_to(err_pc);
		wait_out_valid(waited);
		check_instruction(out, err_pc, 1'b1);
		if (ar_log.size() - start_ar != 1) begin
			report_failure("error fetch did not read exactly once");
		end else begin
			check_ar(start_ar, err_base, 4'd3, fetch_pkg::burst_incr);
		end
		redirect_to(err_pc); // the failed line must still be missing.
		take_instruction(item, waited);
		check_instruction(item, err_pc, 1'b1);
		if (ar_log.size() - start_ar != 2) begin
			report_failure("refetch of a failed line did not go to the bus");
		end else begin
			check_ar(start_ar + 1, err_base, 4'd3, fetch_pkg::burst_incr);
		end
		close_test("bus error", start_errors);
	endtask

	initial begin
		seed = rand_seed;
		rst_n = 1'b0;
		out_ready = 1'b0;
		redirect_valid = 1'b0;
		redirect_pc = '0;
		repeat (8) @(negedge clock);
		rst_n = 1'b1;
		uncached_sequence();
		line_fill();
		cache_reuse();
		decode_backpressure();
		redirect_during_fill();
		error_refetch();
		$display("tests run %0d, tests failed %0d, errors %0d", tests_run, tests_failed, errors);
		if (errors == 0) begin
			$display("Simulation passed");
		end else begin
			$display("Simulation failed");
		end
		$finish;
	end

endmodule

//--- sim.f
hdl/fetch_pkg.sv
hdl/fetch_icache.sv
hdl/fetch_unit.sv
hdl/fetch_top.sv
bench/fetch_mem_model.sv
bench/fetch_tb.sv

//--- Bender.yml
package:
  name: fetch_subsystem

dependencies: {}

sources:
  # RTL in compile order
  - hdl/fetch_pkg.sv
  - hdl/fetch_icache.sv
  - hdl/fetch_unit.sv
  - hdl/fetch_top.sv

  # simulation only, top module fetch_tb
  - target: test
    files:
      - bench/fetch_mem_model.sv
      - bench/fetch_tb.sv
